/* design/trace_pkg.sv */
// Encodings assume a 32-bit AXI-lite data bus and register byte offsets below 0x100
package trace_pkg;

   // ------------------------------
   // Bus widths
   // ------------------------------
   localparam int DATA_W = 32;           // Register and bus data
   localparam int STRB_W = DATA_W / 8;   // One strobe per byte lane
   localparam int REG_AW = 8;            // Byte offset space

   localparam logic [DATA_W-1:0] RDATA_UNMAPPED = 32'h5A5AA5A5;   // Returned for holes

   // ------------------------------
   // Register map
   // ------------------------------
   typedef enum logic [REG_AW-1:0] {
      ADDR_SNAP_CONTROL = 8'h00,   // Start in, idle out
      ADDR_USER_STATUS  = 8'h30,   // Read only
      ADDR_USER_CONTROL = 8'h34,
      ADDR_USER_MODE    = 8'h38,
      ADDR_INIT_RDATA   = 8'h3C,
      ADDR_INIT_WDATA   = 8'h40,
      ADDR_TT_RD_CMD    = 8'h44,   // Trace pop on read
      ADDR_TT_WR_CMD    = 8'h4C,   // Trace pop on read
      ADDR_RD_PATTERN   = 8'h64,
      ADDR_RD_NUMBER    = 8'h68,
      ADDR_WR_PATTERN   = 8'h6C,
      ADDR_WR_NUMBER    = 8'h70
   } reg_addr_e;

   // Sequencer states, order matters for the ready flag
   typedef enum logic [2:0] {
      ST_IDLE     = 3'd0,
      ST_CLEAR    = 3'd1,   // Trace RAM wipe
      ST_READY    = 3'd2,
      ST_RUN      = 3'd3,
      ST_DONE     = 3'd4,
      ST_FINISHED = 3'd5    // Dump finished, idle reported
   } ctrl_state_e;

   // User status bits
   localparam int STAT_WR_DONE      = 0;
   localparam int STAT_RD_DONE      = 1;
   localparam int STAT_WR_ERR       = 2;
   localparam int STAT_RD_ERR_LO    = 3;   // Two bits wide
   localparam int STAT_ENGINE_READY = 5;

   // User control bits
   localparam int CTRL_ENGINE_START = 0;
   localparam int CTRL_FINISH_DUMP  = 1;

endpackage

/* design/ctrl_if.sv */
// Carries levels only, no clock; both ends sample in the same clock domain
`timescale 1ns/1ps

interface ctrl_if
   import trace_pkg::*;
();

   // Register file side
   logic              snap_start;         // Snap control bit 0
   logic              engine_start_lvl;   // User control start bit, level
   logic              finish_dump;
   logic [DATA_W-1:0] rd_number;
   logic [DATA_W-1:0] wr_number;

   // Sequencer side
   ctrl_state_e       state;
   logic              rd_done;            // Sticky
   logic              wr_done;            // Sticky
   logic [1:0]        rd_err;
   logic              wr_err;

   modport regs (
      output snap_start, engine_start_lvl, finish_dump, rd_number, wr_number,
      input  state, rd_done, wr_done, rd_err, wr_err
   );

   modport seq (
      input  snap_start, engine_start_lvl, finish_dump, rd_number, wr_number,
      output state, rd_done, wr_done, rd_err, wr_err
   );

endinterface

/* design/reg_file.sv */
// One outstanding transaction per channel; bresp and rresp are tied off by the parent
`timescale 1ns/1ps

module reg_file
   import trace_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   // AXI-lite slave
   input  logic [REG_AW-1:0] s_axi_awaddr,
   input  logic              s_axi_awvalid,
   output logic              s_axi_awready,
   input  logic [DATA_W-1:0] s_axi_wdata,
   input  logic [STRB_W-1:0] s_axi_wstrb,
   input  logic              s_axi_wvalid,
   output logic              s_axi_wready,
   output logic              s_axi_bvalid,
   input  logic              s_axi_bready,
   input  logic [REG_AW-1:0] s_axi_araddr,
   input  logic              s_axi_arvalid,
   output logic              s_axi_arready,
   output logic [DATA_W-1:0] s_axi_rdata,
   output logic              s_axi_rvalid,
   input  logic              s_axi_rready,
   ctrl_if.regs              ctrl,
   // Engine settings
   output logic              wrap_mode,       // 1 wrap, 0 incr
   output logic [3:0]        wrap_len,
   output logic [DATA_W-1:0] rd_init_data,
   output logic [DATA_W-1:0] wr_init_data,
   output logic [DATA_W-1:0] rd_pattern,
   output logic [DATA_W-1:0] rd_number,
   output logic [DATA_W-1:0] wr_pattern,
   output logic [DATA_W-1:0] wr_number,
   // Trace RAM access
   output logic              tt_rd_cmd_pop,
   output logic              tt_wr_cmd_pop,
   input  logic [DATA_W-1:0] tt_rd_cmd_data,
   input  logic [DATA_W-1:0] tt_wr_cmd_data
);

   reg_addr_e         wr_addr;        // Captured on AW handshake
   reg_addr_e         rd_addr;
   logic              aw_hs, w_hs, ar_hs;
   logic [DATA_W-1:0] wr_mask;
   logic [DATA_W-1:0] snap_ctrl;
   logic [DATA_W-1:0] user_ctrl;
   logic [DATA_W-1:0] user_mode;
   logic [DATA_W-1:0] snap_rd;        // Snap control as seen by software
   logic [DATA_W-1:0] status;
   logic              engine_ready, idle;

   assign aw_hs   = s_axi_awvalid & s_axi_awready;
   assign w_hs    = s_axi_wvalid & s_axi_wready;
   assign ar_hs   = s_axi_arvalid & s_axi_arready;
   assign rd_addr = reg_addr_e'(s_axi_araddr);

   // Keep unstrobed lanes of the old value
   function automatic logic [DATA_W-1:0] merge(input logic [DATA_W-1:0] cur);
      return (s_axi_wdata & wr_mask) | (cur & ~wr_mask);
   endfunction

   // ------------------------------
   // Write channels
   // ------------------------------
   always_ff @(posedge clk) begin
      if (aw_hs) wr_addr <= reg_addr_e'(s_axi_awaddr);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s_axi_awready <= 1'b0;
         s_axi_wready  <= 1'b0;
         s_axi_bvalid  <= 1'b0;
      end else begin
         if (s_axi_awvalid) s_axi_awready <= 1'b1;      // Ready the clock after valid
         else if (w_hs) s_axi_awready <= 1'b0;
         if (aw_hs) s_axi_wready <= 1'b1;
         else if (s_axi_wvalid) s_axi_wready <= 1'b0;
         if (w_hs) s_axi_bvalid <= 1'b1;
         else if (s_axi_bready) s_axi_bvalid <= 1'b0;   // Held until accepted
      end
   end

   always_comb begin
      for (int i = 0; i < STRB_W; i++) begin
         wr_mask[8*i +: 8] = {8{s_axi_wstrb[i]}};
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         snap_ctrl    <= '0;
         user_ctrl    <= '0;
         user_mode    <= '0;
         rd_init_data <= '0;
         wr_init_data <= '0;
         rd_pattern   <= '0;
         rd_number    <= '0;
         wr_pattern   <= '0;
         wr_number    <= '0;
      end else if (w_hs) begin
         case (wr_addr)
            ADDR_SNAP_CONTROL: snap_ctrl    <= merge(snap_ctrl);
            ADDR_USER_CONTROL: user_ctrl    <= merge(user_ctrl);
            ADDR_USER_MODE:    user_mode    <= merge(user_mode);
            ADDR_INIT_RDATA:   rd_init_data <= merge(rd_init_data);
            ADDR_INIT_WDATA:   wr_init_data <= merge(wr_init_data);
            ADDR_RD_PATTERN:   rd_pattern   <= merge(rd_pattern);
            ADDR_RD_NUMBER:    rd_number    <= merge(rd_number);
            ADDR_WR_PATTERN:   wr_pattern   <= merge(wr_pattern);
            ADDR_WR_NUMBER:    wr_number    <= merge(wr_number);
            default: ;                                  // Read-only or hole
         endcase
      end
   end

   // ------------------------------
   // Control out, status in
   // ------------------------------
   assign ctrl.snap_start       = snap_ctrl[0];
   assign ctrl.engine_start_lvl = user_ctrl[CTRL_ENGINE_START];
   assign ctrl.finish_dump      = user_ctrl[CTRL_FINISH_DUMP];
   assign ctrl.rd_number        = rd_number;
   assign ctrl.wr_number        = wr_number;
   assign wrap_mode             = user_mode[0];
   assign wrap_len              = user_mode[11:8];

   assign engine_ready = ctrl.state inside {ST_READY, ST_RUN, ST_DONE, ST_FINISHED};
   assign idle         = (ctrl.state == ST_FINISHED);
   assign snap_rd      = {snap_ctrl[DATA_W-1:4], 1'b1, idle, 1'b0, snap_ctrl[0]};

   always_comb begin
      status                      = '0;
      status[STAT_WR_DONE]        = ctrl.wr_done;
      status[STAT_RD_DONE]        = ctrl.rd_done;
      status[STAT_WR_ERR]         = ctrl.wr_err;
      status[STAT_RD_ERR_LO +: 2] = ctrl.rd_err;
      status[STAT_ENGINE_READY]   = engine_ready;
   end

   // ------------------------------
   // Read channel
   // ------------------------------
   assign tt_rd_cmd_pop = ar_hs && (rd_addr == ADDR_TT_RD_CMD);   // Pointer steps after sampling
   assign tt_wr_cmd_pop = ar_hs && (rd_addr == ADDR_TT_WR_CMD);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s_axi_arready <= 1'b1;                      // Open after reset
         s_axi_rvalid  <= 1'b0;
      end else begin
         if (s_axi_arvalid) s_axi_arready <= 1'b0;
         else if (s_axi_rvalid && s_axi_rready) s_axi_arready <= 1'b1;
         if (ar_hs) s_axi_rvalid <= 1'b1;
         else if (s_axi_rready) s_axi_rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (ar_hs) begin
         case (rd_addr)
            ADDR_SNAP_CONTROL: s_axi_rdata <= snap_rd;
            ADDR_USER_STATUS:  s_axi_rdata <= status;
            ADDR_USER_CONTROL: s_axi_rdata <= user_ctrl;
            ADDR_USER_MODE:    s_axi_rdata <= user_mode;
            ADDR_INIT_RDATA:   s_axi_rdata <= rd_init_data;
            ADDR_INIT_WDATA:   s_axi_rdata <= wr_init_data;
            ADDR_TT_RD_CMD:    s_axi_rdata <= tt_rd_cmd_data;
            ADDR_TT_WR_CMD:    s_axi_rdata <= tt_wr_cmd_data;
            ADDR_RD_PATTERN:   s_axi_rdata <= rd_pattern;
            ADDR_RD_NUMBER:    s_axi_rdata <= rd_number;
            ADDR_WR_PATTERN:   s_axi_rdata <= wr_pattern;
            ADDR_WR_NUMBER:    s_axi_rdata <= wr_number;
            default:           s_axi_rdata <= RDATA_UNMAPPED;
         endcase
      end
   end

endmodule

/* design/engine_seq.sv */
// Runs once per reset; ST_FINISHED is terminal and a start written before ready is ignored
`timescale 1ns/1ps

module engine_seq
   import trace_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   ctrl_if.seq        ctrl,
   input  logic       clear_done,        // Last clear cycle
   input  logic       rd_done_pulse,
   input  logic       wr_done_pulse,
   input  logic [1:0] rd_error,          // Bit 0 response, bit 1 data
   input  logic       wr_error,
   output logic       clearing,
   output logic       running,
   output logic       engine_start_pulse
);

   ctrl_state_e state, state_nxt;
   logic        start_q;                 // Start level, one clock late

   assign ctrl.state = state;
   assign clearing   = (state == ST_CLEAR);
   assign running    = (state == ST_RUN);

   // Rising edge of the start bit, honoured only when ready
   assign engine_start_pulse = (state == ST_READY) && ctrl.engine_start_lvl && !start_q;

   // ------------------------------
   // State machine
   // ------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE:  if (ctrl.snap_start) state_nxt = ST_CLEAR;
         ST_CLEAR: if (clear_done) state_nxt = ST_READY;
         ST_READY: if (engine_start_pulse) state_nxt = ST_RUN;
         ST_RUN:   if (ctrl.rd_done && ctrl.wr_done) state_nxt = ST_DONE;
         ST_DONE:  if (ctrl.finish_dump) state_nxt = ST_FINISHED;
         default:  state_nxt = state;    // Finished holds
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= ST_IDLE;
         start_q <= 1'b0;
      end else begin
         state   <= state_nxt;
         start_q <= ctrl.engine_start_lvl;
      end
   end

   // ------------------------------
   // Sticky status flags
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl.rd_done <= 1'b0;
         ctrl.wr_done <= 1'b0;
         ctrl.rd_err  <= 2'b00;
         ctrl.wr_err  <= 1'b0;
      end else begin
         // Zero count means nothing to wait for
         if (rd_done_pulse || (engine_start_pulse && ctrl.rd_number == '0))
            ctrl.rd_done <= 1'b1;
         if (wr_done_pulse || (engine_start_pulse && ctrl.wr_number == '0))
            ctrl.wr_done <= 1'b1;
         ctrl.rd_err <= ctrl.rd_err | rd_error;   // Any state
         ctrl.wr_err <= ctrl.wr_err | wr_error;
      end
   end

endmodule

/* design/cycle_timer.sv */
// Clear length is the trace depth; the run counter wraps silently after 2**32 cycles
`timescale 1ns/1ps

module cycle_timer
   import trace_pkg::*;
#(
   parameter int TRACE_AW = 12           // log2 of trace depth
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              clearing,
   input  logic              running,
   output logic              clear_done,
   output logic [DATA_W-1:0] cycle       // Event stamp
);

   logic [TRACE_AW-1:0] clear_cnt;
   logic                running_q;

   // ------------------------------
   // Clear countdown
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) clear_cnt <= '1;
      else if (!clearing) clear_cnt <= '1;        // Reload between uses
      else if (clear_cnt != '0) clear_cnt <= clear_cnt - 1'b1;
   end

   assign clear_done = clearing && (clear_cnt == '0);   // 2**TRACE_AW cycles in

   // ------------------------------
   // Run cycle counter
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         running_q <= 1'b0;
         cycle     <= '0;
      end else begin
         running_q <= running;
         if (running && !running_q) cycle <= '0;    // First run clock
         else if (running) cycle <= cycle + 1'b1;
      end
   end

endmodule

/* design/trace_ram.sv */
// Single pointer shared by writes and pops, so reading during a run reorders entries
`timescale 1ns/1ps

module trace_ram
   import trace_pkg::*;
#(
   parameter int TRACE_AW = 12
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              evt,        // Traced command seen
   input  logic              pop,        // MMIO read of this RAM
   input  logic              rewind,
   input  logic              clearing,
   input  logic [DATA_W-1:0] stamp,
   output logic [DATA_W-1:0] entry
);

   localparam int DEPTH = 2 ** TRACE_AW;

   logic [DATA_W-1:0]   mem [DEPTH];
   logic [TRACE_AW-1:0] ptr;

   // Pointer, rewind wins
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) ptr <= '0;
      else if (rewind) ptr <= '0;
      else if (clearing || evt || pop) ptr <= ptr + 1'b1;   // Wraps after a full clear
   end

   // Storage
   always_ff @(posedge clk) begin
      if (clearing) mem[ptr] <= '0;
      else if (evt) mem[ptr] <= stamp;
   end

   assign entry = mem[ptr];   // Combinational, sampled by the read mux

endmodule

/* design/trace_top.sv */
// Responses are always OKAY; trace inputs are one-cycle pulses from the engine
`timescale 1ns/1ps

module trace_top
   import trace_pkg::*;
#(
   parameter int TRACE_AW = 12
) (
   input  logic              clk,
   input  logic              rst_n,
   // AXI-lite slave
   input  logic [REG_AW-1:0] s_axi_awaddr,
   input  logic              s_axi_awvalid,
   output logic              s_axi_awready,
   input  logic [DATA_W-1:0] s_axi_wdata,
   input  logic [STRB_W-1:0] s_axi_wstrb,
   input  logic              s_axi_wvalid,
   output logic              s_axi_wready,
   output logic [1:0]        s_axi_bresp,
   output logic              s_axi_bvalid,
   input  logic              s_axi_bready,
   input  logic [REG_AW-1:0] s_axi_araddr,
   input  logic              s_axi_arvalid,
   output logic              s_axi_arready,
   output logic [DATA_W-1:0] s_axi_rdata,
   output logic [1:0]        s_axi_rresp,
   output logic              s_axi_rvalid,
   input  logic              s_axi_rready,
   // Engine control
   output logic              engine_start_pulse,
   output logic              wrap_mode,
   output logic [3:0]        wrap_len,
   output logic [DATA_W-1:0] rd_init_data,
   output logic [DATA_W-1:0] wr_init_data,
   output logic [DATA_W-1:0] rd_pattern,
   output logic [DATA_W-1:0] rd_number,
   output logic [DATA_W-1:0] wr_pattern,
   output logic [DATA_W-1:0] wr_number,
   // Engine status
   input  logic              rd_done_pulse,
   input  logic              wr_done_pulse,
   input  logic [1:0]        rd_error,
   input  logic              wr_error,
   input  logic              tt_arvalid,   // arvalid & arready of the engine
   input  logic              tt_awvalid    // awvalid & awready of the engine
);

   logic              clearing, running, clear_done;
   logic [DATA_W-1:0] cycle;
   logic              tt_rd_cmd_pop, tt_wr_cmd_pop;
   logic [DATA_W-1:0] tt_rd_cmd_data, tt_wr_cmd_data;

   assign s_axi_bresp = 2'b00;
   assign s_axi_rresp = 2'b00;

   ctrl_if u_ctrl ();

   reg_file u_reg_file (
      .clk, .rst_n,
      .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
      .s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
      .s_axi_bvalid, .s_axi_bready,
      .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
      .s_axi_rdata, .s_axi_rvalid, .s_axi_rready,
      .ctrl (u_ctrl.regs),
      .wrap_mode, .wrap_len, .rd_init_data, .wr_init_data,
      .rd_pattern, .rd_number, .wr_pattern, .wr_number,
      .tt_rd_cmd_pop, .tt_wr_cmd_pop, .tt_rd_cmd_data, .tt_wr_cmd_data
   );

   engine_seq u_engine_seq (
      .clk, .rst_n,
      .ctrl (u_ctrl.seq),
      .clear_done, .rd_done_pulse, .wr_done_pulse, .rd_error, .wr_error,
      .clearing, .running, .engine_start_pulse
   );

   cycle_timer #(.TRACE_AW(TRACE_AW)) u_cycle_timer (
      .clk, .rst_n, .clearing, .running, .clear_done, .cycle
   );

   // Read command trace, rewound on read completion or any read error
   trace_ram #(.TRACE_AW(TRACE_AW)) u_tt_rd_cmd (
      .clk, .rst_n, .evt (tt_arvalid), .pop (tt_rd_cmd_pop),
      .rewind (rd_done_pulse | (|rd_error)), .clearing, .stamp (cycle),
      .entry (tt_rd_cmd_data)
   );

   trace_ram #(.TRACE_AW(TRACE_AW)) u_tt_wr_cmd (
      .clk, .rst_n, .evt (tt_awvalid), .pop (tt_wr_cmd_pop),
      .rewind (wr_done_pulse | wr_error), .clearing, .stamp (cycle),
      .entry (tt_wr_cmd_data)
   );

endmodule

/* include/tb_axil_tasks.svh */
// Include inside the testbench module; expects clk and s_axi_* signals of the DUT in scope
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// Single write, returns after the B handshake is set up
task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
   @(negedge clk);
   s_axi_awaddr  = addr;
   s_axi_awvalid = 1'b1;
   s_axi_wdata   = data;
   s_axi_wstrb   = strb;
   s_axi_wvalid  = 1'b1;                   // wready only opens after AW
   s_axi_bready  = 1'b1;
   while (!s_axi_awready) @(negedge clk);
   @(negedge clk);                         // AW handshake taken
   s_axi_awvalid = 1'b0;
   while (!s_axi_bvalid) @(negedge clk);
   s_axi_wvalid  = 1'b0;
endtask

// Single read, data sampled while rvalid is high
task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
   @(negedge clk);
   s_axi_araddr  = addr;
   s_axi_arvalid = 1'b1;
   s_axi_rready  = 1'b1;
   while (!s_axi_arready) @(negedge clk);
   @(negedge clk);                         // AR handshake taken
   s_axi_arvalid = 1'b0;
   while (!s_axi_rvalid) @(negedge clk);
   data = s_axi_rdata;
endtask

`endif

/* bench/tb_trace_top.sv */
// TRACE_AW = 4, one AXI-lite transaction in flight; include/ must be on the include path
`timescale 1ns/1ps

module tb_trace_top
   import trace_pkg::*;
();

   localparam int TRACE_AW     = 4;
   localparam int CLK_PERIOD   = 100;
   localparam int CLEAR_CYCLES = 2 ** TRACE_AW;
   localparam int WATCHDOG_CYC = 40 * 10 + CLEAR_CYCLES + 200;   // 40 transactions budget
   localparam int N_RW         = 7;

   // Writable registers, index matches shadow
   localparam reg_addr_e RW_REGS [N_RW] = '{ADDR_USER_MODE, ADDR_INIT_RDATA, ADDR_INIT_WDATA,
      ADDR_RD_PATTERN, ADDR_RD_NUMBER, ADDR_WR_PATTERN, ADDR_WR_NUMBER};

   logic              clk, rst_n;
   logic [REG_AW-1:0] s_axi_awaddr, s_axi_araddr;
   logic              s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
   logic [DATA_W-1:0] s_axi_wdata, s_axi_rdata;
   logic [STRB_W-1:0] s_axi_wstrb;
   logic [1:0]        s_axi_bresp, s_axi_rresp;
   logic              s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
   logic              s_axi_rvalid, s_axi_rready;
   logic              engine_start_pulse, wrap_mode;
   logic [3:0]        wrap_len;
   logic [DATA_W-1:0] rd_init_data, wr_init_data, rd_pattern, rd_number, wr_pattern, wr_number;
   logic              rd_done_pulse, wr_done_pulse, wr_error, tt_arvalid, tt_awvalid;
   logic [1:0]        rd_error;
   integer            seed;
   int                pulse_count;                // Start pulses seen since reset
   logic [DATA_W-1:0] shadow [N_RW];              // Expected register contents

   `include "tb_axil_tasks.svh"

   trace_top #(.TRACE_AW(TRACE_AW)) UUT (
      .clk, .rst_n,
      .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
      .s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
      .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
      .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
      .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
      .engine_start_pulse, .wrap_mode, .wrap_len, .rd_init_data, .wr_init_data,
      .rd_pattern, .rd_number, .wr_pattern, .wr_number,
      .rd_done_pulse, .wr_done_pulse, .rd_error, .wr_error, .tt_arvalid, .tt_awvalid
   );

   // ------------------------------
   // Clock, watchdog, pulse monitor
   // ------------------------------
   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYC);
      $display("Done: errors found");
      $fatal(1);
   end

   always @(negedge clk) begin
      if (rst_n && engine_start_pulse) pulse_count = pulse_count + 1;   // Stable between edges
   end

   // ------------------------------
   // Helpers
   // ------------------------------
   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   // Responses must be OKAY whenever valid
   always @(negedge clk) begin
      if (rst_n && s_axi_bvalid) check_value("bresp", 32'h0, {30'b0, s_axi_bresp});
      if (rst_n && s_axi_rvalid) check_value("rresp", 32'h0, {30'b0, s_axi_rresp});
   end

   // Byte lanes with strobe set take the new data
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0] strb);
      logic [31:0] res;
      for (int i = 0; i < 4; i++) begin
         res[8*i +: 8] = strb[i] ? new_val[8*i +: 8] : old_val[8*i +: 8];
      end
      return res;
   endfunction

   function automatic logic [31:0] expected_status(input logic wr_done, input logic rd_done,
                                                   input logic wr_err, input logic [1:0] rd_err,
                                                   input logic ready);
      logic [31:0] res;
      res                      = '0;
      res[STAT_WR_DONE]        = wr_done;
      res[STAT_RD_DONE]        = rd_done;
      res[STAT_WR_ERR]         = wr_err;
      res[STAT_RD_ERR_LO +: 2] = rd_err;
      res[STAT_ENGINE_READY]   = ready;
      return res;
   endfunction

   // Snap control with upper bits written as zero
   function automatic logic [31:0] expected_snap(input logic start, input logic idle);
      return {28'b0, 1'b1, idle, 1'b0, start};
   endfunction

   task automatic apply_reset();
      rst_n       = 1'b0;
      pulse_count = 0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      // awready, wready, bvalid, rvalid, arready, start pulse
      check_value("outputs after reset", 32'b000010,
                  {26'b0, s_axi_awready, s_axi_wready, s_axi_bvalid, s_axi_rvalid,
                   s_axi_arready, engine_start_pulse});
   endtask

   // ------------------------------
   // Tests
   // ------------------------------
   task automatic run_register_test();
      logic [31:0] data, rnd, rd;
      logic [3:0]  strb;
      for (int i = 0; i < N_RW; i++) begin
         data = $random(seed);
         axil_write(RW_REGS[i], data, 4'hF);       // Known base value
         shadow[i] = data;
         data = $random(seed);
         rnd  = $random(seed);
         strb = rnd[3:0];
         axil_write(RW_REGS[i], data, strb);
         shadow[i] = merge_bytes(shadow[i], data, strb);
         axil_read(RW_REGS[i], rd);
         check_value($sformatf("readback 0x%02h", RW_REGS[i]), shadow[i], rd);
      end
      axil_read(8'h04, rd);                         // Hole in the map
      check_value("unmapped read", 32'h5A5AA5A5, rd);
      check_value("wrap_mode", {31'b0, shadow[0][0]}, {31'b0, wrap_mode});
      check_value("wrap_len", {28'b0, shadow[0][11:8]}, {28'b0, wrap_len});
      check_value("rd_init_data", shadow[1], rd_init_data);
      check_value("wr_init_data", shadow[2], wr_init_data);
      check_value("rd_pattern", shadow[3], rd_pattern);
      check_value("rd_number", shadow[4], rd_number);
      check_value("wr_pattern", shadow[5], wr_pattern);
      check_value("wr_number", shadow[6], wr_number);
   endtask

   task automatic run_start_test();
      logic [31:0] rd;
      axil_read(ADDR_USER_STATUS, rd);
      check_value("status before snap start", expected_status(0, 0, 0, 2'b00, 0), rd);
      axil_write(ADDR_SNAP_CONTROL, 32'h1, 4'hF);
      repeat (CLEAR_CYCLES + 10) @(negedge clk);   // Trace clear plus margin
      axil_read(ADDR_USER_STATUS, rd);
      check_value("status after clear", expected_status(0, 0, 0, 2'b00, 1), rd);
      axil_read(ADDR_SNAP_CONTROL, rd);
      check_value("snap control while ready", expected_snap(1'b1, 1'b0), rd);
   endtask

   task automatic run_zero_count_test();
      logic [31:0] rd;
      axil_write(ADDR_RD_NUMBER, 32'h0, 4'hF);
      axil_write(ADDR_WR_NUMBER, 32'h0, 4'hF);
      check_value("rd_number zeroed", 32'h0, rd_number);
      check_value("wr_number zeroed", 32'h0, wr_number);
      axil_write(ADDR_USER_CONTROL, 32'd1 << CTRL_ENGINE_START, 4'hF);
      axil_read(ADDR_USER_STATUS, rd);
      check_value("status zero counts", expected_status(1, 1, 0, 2'b00, 1), rd);
      check_value("start pulse count", 32'd1, pulse_count);
   endtask

   task automatic run_trace_test();
      logic [31:0] stamps [3];
      logic [31:0] rd;
      axil_write(ADDR_RD_NUMBER, 32'd3, 4'hF);
      axil_write(ADDR_WR_NUMBER, 32'd1, 4'hF);
      axil_write(ADDR_SNAP_CONTROL, 32'h1, 4'hF);
      repeat (CLEAR_CYCLES + 10) @(negedge clk);
      axil_write(ADDR_USER_CONTROL, 32'd1 << CTRL_ENGINE_START, 4'hF);
      repeat (3) @(negedge clk);                   // Counter running from here
      tt_arvalid = 1'b1;                           // First read command, write command alongside
      tt_awvalid = 1'b1;
      @(negedge clk);
      tt_arvalid = 1'b0;
      tt_awvalid = 1'b0;
      repeat (2) @(negedge clk);
      tt_arvalid = 1'b1;                           // 3 cycles after the first
      @(negedge clk);
      tt_arvalid = 1'b0;
      repeat (4) @(negedge clk);
      tt_arvalid = 1'b1;                           // 5 cycles after the second
      @(negedge clk);
      tt_arvalid = 1'b0;
      @(negedge clk);
      rd_done_pulse = 1'b1;                        // Rewinds both RAMs
      wr_done_pulse = 1'b1;
      @(negedge clk);
      rd_done_pulse = 1'b0;
      wr_done_pulse = 1'b0;
      for (int k = 0; k < 3; k++) axil_read(ADDR_TT_RD_CMD, stamps[k]);
      check_value("rd trace first gap", 32'd3, stamps[1] - stamps[0]);
      check_value("rd trace second gap", 32'd5, stamps[2] - stamps[1]);
      axil_read(ADDR_TT_WR_CMD, rd);
      check_value("wr trace stamp", stamps[0], rd);
      axil_read(ADDR_USER_STATUS, rd);
      check_value("status after done pulses", expected_status(1, 1, 0, 2'b00, 1), rd);
      check_value("start pulse count after trace", 32'd1, pulse_count);
   endtask

   task automatic run_error_finish_test();
      logic [31:0] rd;
      @(negedge clk);
      rd_error = 2'b10;
      wr_error = 1'b1;
      @(negedge clk);
      rd_error = 2'b00;                            // Flags must hold from here
      wr_error = 1'b0;
      axil_read(ADDR_USER_STATUS, rd);
      check_value("sticky error bits", expected_status(1, 1, 1, 2'b10, 1), rd);
      axil_write(ADDR_USER_CONTROL, (32'd1 << CTRL_ENGINE_START) | (32'd1 << CTRL_FINISH_DUMP),
                 4'hF);
      axil_read(ADDR_SNAP_CONTROL, rd);
      check_value("snap control idle", expected_snap(1'b1, 1'b1), rd);
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial begin
      seed          = 3;
      rst_n         = 1'b0;
      s_axi_awaddr  = '0;
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = '0;
      s_axi_wstrb   = '0;
      s_axi_wvalid  = 1'b0;
      s_axi_bready  = 1'b0;
      s_axi_araddr  = '0;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b0;
      rd_done_pulse = 1'b0;
      wr_done_pulse = 1'b0;
      rd_error      = 2'b00;
      wr_error      = 1'b0;
      tt_arvalid    = 1'b0;
      tt_awvalid    = 1'b0;

      apply_reset();
      run_register_test();
      run_start_test();
      run_zero_count_test();
      apply_reset();                               // Fresh engine for tracing
      run_trace_test();
      run_error_finish_test();

      $display("Done: no errors");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+include
design/trace_pkg.sv
design/ctrl_if.sv
design/reg_file.sv
design/engine_seq.sv
design/cycle_timer.sv
design/trace_ram.sv
design/trace_top.sv
bench/tb_trace_top.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f filelist.f --top-module tb_trace_top -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

./obj_dir/Vtb_trace_top > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed"
exit 1
